/* Makefile */
TOP = tb_div_top
OBJ = obj_dir

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f all.f -Mdir $(OBJ) -o sim
	./$(OBJ)/sim | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf $(OBJ) sim.log

/* all.f */
src/div_pkg.sv
src/div_array.sv
src/div_datapath.sv
src/div_regs.sv
src/div_top.sv
testbench/div_assertions.sv
testbench/tb_div_top.sv

/* src/div_array.sv */
`default_nettype none

// Restoring array divider. Row i produces quotient bit i; rows below
// approx_rows use the approximate subtractor cell.
module div_array import div_pkg::*; (
  input  logic [n_width-1:0]    n,
  input  logic [d_width-1:0]    d,
  input  logic [rows_width-1:0] approx_rows,
  output logic [q_width-1:0]    q,
  output logic [q_width-1:0]    r
);

  logic [d_width-1:0] rem [q_width]; // Partial remainder leaving each row.

  for (genvar i = 0; i < q_width; i++) begin : g_row
    logic               approx;
    logic               top;
    logic [d_width-1:0] x;
    logic [d_width-1:0] bin;
    logic [d_width-1:0] bout;
    logic [d_width-1:0] diff;

    assign approx = approx_rows > rows_width'(i);

    if (i == q_width - 1) begin : g_first
      assign x   = n[n_width-2 -: d_width]; // Dividend bits 14:7.
      assign top = n[n_width-1];
    end else begin : g_next
      // Shift the row above down and bring in the next dividend bit.
      assign x   = {rem[i+1][d_width-2:0], n[i]};
      assign top = rem[i+1][d_width-1];
    end

    assign bin = {bout[d_width-2:0], 1'b0}; // Borrow chain, LSB first.

    for (genvar j = 0; j < d_width; j++) begin : g_cell
      logic diff_exact;
      logic bout_exact;
      logic diff_apx;
      logic bout_apx;

      assign diff_exact = x[j] ^ d[j] ^ bin[j];
      assign bout_exact = (~x[j] & d[j]) | (~(x[j] ^ d[j]) & bin[j]);

      assign diff_apx = x[j];
      assign bout_apx = ~bin[j] | x[j];

      assign diff[j] = approx ? diff_apx : diff_exact;
      assign bout[j] = approx ? bout_apx : bout_exact;
    end

    assign q[i]   = top | ~bout[d_width-1];
    assign rem[i] = q[i] ? diff : x; // Restore when the subtraction fails.
  end

  assign r = rem[0];

endmodule

`default_nettype wire

/* src/div_datapath.sv */
`default_nettype none

module div_datapath import div_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [rows_width-1:0] approx_rows,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  div_req_t              in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output div_rsp_t              out_data,
  output logic                  done,
  output logic                  ovf
);

  logic                 advance;
  logic                 s1_valid;
  div_req_t             s1_req;
  logic                 s1_ovf;
  logic [q_width-1:0]   arr_q;
  logic [q_width-1:0]   arr_r;

  // Whole pipe moves together.
  assign advance  = ~out_valid | out_ready;
  assign in_ready = advance;

  div_array u_array (
    .n           (s1_req.n),
    .d           (s1_req.d),
    .approx_rows (s1_req.approx_rows),
    .q           (arr_q),
    .r           (arr_r)
  );

  // Covers divide by zero as well.
  assign s1_ovf = s1_req.n[n_width-1 -: d_width] >= s1_req.d;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // Stage 1. The live setting replaces whatever the requester sent.
  always_ff @(posedge clk) begin
    if (advance && in_valid) begin
      s1_req.n           <= in_data.n;
      s1_req.d           <= in_data.d;
      s1_req.approx_rows <= approx_rows;
    end
  end

  // Stage 2.
  always_ff @(posedge clk) begin
    if (advance && s1_valid) begin
      out_data.q   <= arr_q;
      out_data.r   <= arr_r;
      out_data.ovf <= s1_ovf;
    end
  end

  assign done = out_valid & out_ready; // One pulse per result transfer.
  assign ovf  = done & out_data.ovf;

endmodule

`default_nettype wire

/* src/div_pkg.sv */
`default_nettype none

package div_pkg;

  // Operand and result widths.
  localparam int n_width    = 16;
  localparam int d_width    = 8;
  localparam int q_width    = 8;
  localparam int rows_width = 4;

  localparam int max_approx_rows = 8; // Largest legal CTRL value.

  typedef struct packed {
    logic [n_width-1:0]    n;           // Dividend.
    logic [d_width-1:0]    d;           // Divisor.
    logic [rows_width-1:0] approx_rows; // Setting captured at acceptance.
  } div_req_t;

  typedef struct packed {
    logic [q_width-1:0] q;   // Quotient.
    logic [q_width-1:0] r;   // Remainder.
    logic               ovf; // Upper dividend byte not below divisor.
  } div_rsp_t;

  localparam int apb_addr_width = 4;
  localparam int apb_data_width = 32;

  // Register map.
  localparam logic [apb_addr_width-1:0] addr_ctrl       = 4'h0;
  localparam logic [apb_addr_width-1:0] addr_done_count = 4'h4;
  localparam logic [apb_addr_width-1:0] addr_ovf_count  = 4'h8;

  localparam logic [rows_width-1:0] ctrl_reset_rows = 4'd2; // Matches the reference circuit.

  // APB completion codes on pslverr.
  localparam logic apb_ok  = 1'b0;
  localparam logic apb_err = 1'b1;

endpackage

`default_nettype wire

/* src/div_regs.sv */
`default_nettype none

module div_regs import div_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [apb_data_width-1:0] pwdata,
  output logic [apb_data_width-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic                      done,
  input  logic                      ovf,
  output logic [rows_width-1:0]     approx_rows
);

  logic                      access;
  logic                      ctrl_wr;
  logic                      rows_bad;
  logic [apb_data_width-1:0] done_count;
  logic [apb_data_width-1:0] ovf_count;

  assign access   = psel & penable;
  assign pready   = 1'b1; // No wait states.
  assign rows_bad = pwdata > apb_data_width'(max_approx_rows);

  always_comb begin
    prdata  = '0;
    pslverr = apb_ok;
    if (access) begin
      case (paddr)
        addr_ctrl: begin
          prdata = apb_data_width'(approx_rows);
          if (pwrite && rows_bad) begin
            pslverr = apb_err;
          end
        end
        addr_done_count: begin
          prdata = done_count;
          if (pwrite) begin
            pslverr = apb_err; // Read only.
          end
        end
        addr_ovf_count: begin
          prdata = ovf_count;
          if (pwrite) begin
            pslverr = apb_err;
          end
        end
        default: begin
          pslverr = apb_err; // Unmapped offsets read as 0.
        end
      endcase
    end
  end

  assign ctrl_wr = access & pwrite & (paddr == addr_ctrl) & ~rows_bad;

  always_ff @(posedge clk) begin
    if (reset) begin
      approx_rows <= ctrl_reset_rows;
    end else if (ctrl_wr) begin
      approx_rows <= pwdata[rows_width-1:0];
    end
  end

  // Event counters stick at all ones.
  always_ff @(posedge clk) begin
    if (reset) begin
      done_count <= '0;
      ovf_count  <= '0;
    end else begin
      if (done && done_count != '1) begin
        done_count <= done_count + 1'b1;
      end
      if (ovf && ovf_count != '1) begin
        ovf_count <= ovf_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/div_top.sv */
`default_nettype none

module div_top import div_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  // APB register port.
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [apb_data_width-1:0] pwdata,
  output logic [apb_data_width-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  // Operand stream.
  input  logic                      in_valid,
  output logic                      in_ready,
  input  div_req_t                  in_data,
  // Result stream.
  output logic                      out_valid,
  input  logic                      out_ready,
  output div_rsp_t                  out_data
);

  logic [rows_width-1:0] approx_rows;
  logic                  done;
  logic                  ovf;

  div_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .done        (done),
    .ovf         (ovf),
    .approx_rows (approx_rows)
  );

  div_datapath u_datapath (
    .clk         (clk),
    .reset       (reset),
    .approx_rows (approx_rows),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .done        (done),
    .ovf         (ovf)
  );

endmodule

`default_nettype wire

/* testbench/div_assertions.sv */
`default_nettype none

module div_assertions import div_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     in_valid,
  input logic     in_ready,
  input logic     out_valid,
  input logic     out_ready,
  input div_rsp_t out_data,
  input logic     s1_valid,
  input div_req_t s1_req
);
  timeunit 1ns;
  timeprecision 100ps;

  // A stalled result keeps its payload.
  hold_data: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_data))
    else $error("out_data changed while the result was stalled");

  hold_valid: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped before out_ready");

  // Stage 1 must not take an operand the pipe refused.
  no_accept: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> $stable(s1_req) && $stable(s1_valid))
    else $error("stage 1 changed while in_ready was low");

endmodule

`default_nettype wire

/* testbench/tb_div_top.sv */
`default_nettype none

module tb_div_top import div_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_cycles = 20000; // Tests need under 2000 cycles.

  typedef struct packed {
    div_rsp_t    rsp;
    logic        check_qr;
    logic        timed;
    logic [31:0] cycle;
  } exp_t;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [3:0]  paddr = '0;
  logic [31:0] pwdata = '0;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        in_valid = 1'b0;
  logic        in_ready;
  div_req_t    in_data = '0;
  logic        out_valid;
  logic        out_ready = 1'b1;
  div_rsp_t    out_data;

  exp_t        exp_q[$];
  logic [3:0]  ctrl_model = 4'd2; // CTRL value after reset.
  logic        exact_mode = 1'b0;
  logic        ready_random = 1'b0;
  int unsigned cycles = 0;
  int unsigned mismatches = 0;
  int unsigned other_errors = 0;
  int unsigned ops_sent = 0;
  int unsigned ovf_sent = 0;

  always #5 clk = ~clk;

  div_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  bind div_datapath div_assertions asserts0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .s1_valid  (s1_valid),
    .s1_req    (s1_req)
  );

  // Bit-level model of the cell array from row 7 down.
  function automatic logic [15:0] ref_div(input logic [15:0] n, input logic [7:0] d,
                                          input logic [3:0] rows);
    logic [7:0] x;
    logic [7:0] part;
    logic [7:0] diff;
    logic [7:0] q;
    logic [1:0] sub;
    logic       top;
    logic       b;
    part = '0;
    q    = '0;
    diff = '0;
    for (int i = 7; i >= 0; i--) begin
      if (i == 7) begin
        x   = n[14:7];
        top = n[15];
      end else begin
        x   = {part[6:0], n[i]};
        top = part[7];
      end
      b = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (i < int'(rows)) begin
          diff[j] = x[j];
          b       = ~b | x[j];
        end else begin
          sub     = 2'(x[j]) - 2'(d[j]) - 2'(b); // One-bit subtract with borrow.
          diff[j] = sub[0];
          b       = sub[1];
        end
      end
      q[i] = top | ~b;
      part = q[i] ? diff : x;
    end
    return {q, part};
  endfunction

  function automatic exp_t expect_for(input logic [15:0] n, input logic [7:0] d);
    exp_t        e;
    logic [15:0] qr;
    e.rsp.ovf  = n >= {d, 8'h00}; // Quotient would not fit in 8 bits.
    e.check_qr = ~e.rsp.ovf;
    e.timed    = ~ready_random;
    e.cycle    = cycles;
    if (exact_mode && !e.rsp.ovf) begin
      e.rsp.q = 8'(n / 16'(d));
      e.rsp.r = 8'(n % 16'(d));
    end else begin
      qr      = ref_div(n, d, ctrl_model);
      e.rsp.q = qr[15:8];
      e.rsp.r = qr[7:0];
    end
    return e;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("FAIL %0d ns: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  always @(posedge clk) begin
    #1;
    out_ready = ready_random ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  // Expected results are fixed at acceptance.
  always @(negedge clk) begin
    if (!reset && in_valid && in_ready) begin
      exp_q.push_back(expect_for(in_data.n, in_data.d));
    end
  end

  always @(negedge clk) begin
    exp_t e;
    if (!reset && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("A result came out at %0d ns with no operation outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        assert (out_data.ovf == e.rsp.ovf) else
          report_mismatch($sformatf("ovf %0b, expected %0b", out_data.ovf, e.rsp.ovf));
        if (e.check_qr) begin
          assert (out_data.q == e.rsp.q && out_data.r == e.rsp.r) else
            report_mismatch($sformatf("q %0d r %0d, expected q %0d r %0d",
                                      out_data.q, out_data.r, e.rsp.q, e.rsp.r));
        end
        if (e.timed) begin
          assert (cycles - e.cycle == 2) else
            report_mismatch($sformatf("latency %0d cycles, expected 2", cycles - e.cycle));
        end
      end
    end
  end

  // Starts and ends 1 ns after a rising edge.
  task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel   = 1'b1;
    pwrite = write;
    paddr  = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    assert (pready) else report_mismatch("pready low in access phase");
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
                             input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    assert (rdata == exp_data && err == exp_err) else
      report_mismatch($sformatf("read 0x%0h gave 0x%0h err %0b, expected 0x%0h err %0b",
                                addr, rdata, err, exp_data, exp_err));
  endtask

  task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                              input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    assert (err == exp_err) else
      report_mismatch($sformatf("write 0x%0h to 0x%0h gave err %0b, expected %0b",
                                data, addr, err, exp_err));
  endtask

  task automatic write_ctrl(input logic [31:0] value);
    write_expect(addr_ctrl, value, value > 32'd8);
    if (value <= 32'd8) begin
      ctrl_model = value[3:0];
    end
  endtask

  task automatic send_op(input logic [15:0] n, input logic [7:0] d);
    logic accepted;
    in_data.n           = n;
    in_data.d           = d;
    in_data.approx_rows = 4'($urandom); // The DUT substitutes CTRL.
    in_valid            = 1'b1;
    accepted            = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    ops_sent++;
    if (n >= {d, 8'h00}) begin
      ovf_sent++;
    end
  endtask

  // Kind 0 keeps the upper byte below d, kind 2 forces overflow, else any.
  task automatic send_random(input int count, input int kind);
    logic [7:0] d;
    logic [7:0] hi;
    for (int k = 0; k < count; k++) begin
      if (kind == 0) begin
        d  = 8'($urandom_range(255, 1));
        hi = 8'($urandom_range(int'(d) - 1, 0));
      end else if (kind == 2) begin
        d  = ($urandom_range(4, 0) == 0) ? 8'd0 : 8'($urandom);
        hi = 8'($urandom_range(255, int'(d)));
      end else begin
        d  = 8'($urandom);
        hi = 8'($urandom);
      end
      if (ready_random && $urandom_range(3, 0) == 0) begin
        @(posedge clk);
        #1;
      end
      send_op({hi, 8'($urandom)}, d);
    end
  endtask

  task automatic drain();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  initial begin
    void'($urandom(32'h2867_4b03));
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (in_ready && pready && !out_valid && !pslverr) else
      report_mismatch("outputs not at their reset values");
    read_expect(addr_ctrl, 32'd2, 1'b0);
    read_expect(addr_done_count, 32'd0, 1'b0);
    read_expect(addr_ovf_count, 32'd0, 1'b0);
    send_random(40, 1);

    write_ctrl(32'd0);
    exact_mode = 1'b1;
    send_random(500, 0);
    drain();
    exact_mode = 1'b0;

    for (int rows = 0; rows <= 8; rows++) begin
      write_ctrl(32'(rows));
      send_random(40, 1);
    end

    // CTRL changes while operations are in flight.
    fork
      send_random(30, 0);
      begin
        repeat (8) @(posedge clk);
        #1;
        write_ctrl(32'd3);
      end
    join
    drain();

    ready_random = 1'b1;
    send_random(200, 1);
    drain();
    ready_random = 1'b0;
    @(posedge clk);
    #1;

    send_op(16'h1234, 8'h00);
    send_op(16'h0000, 8'h00);
    send_random(50, 2);
    drain();
    read_expect(addr_done_count, ops_sent, 1'b0);
    read_expect(addr_ovf_count, ovf_sent, 1'b0);

    write_ctrl(32'd9);
    read_expect(addr_ctrl, 32'(ctrl_model), 1'b0);
    write_expect(addr_done_count, 32'd123, 1'b1);
    read_expect(addr_done_count, ops_sent, 1'b0);
    write_expect(addr_ovf_count, 32'd77, 1'b1);
    read_expect(addr_ovf_count, ovf_sent, 1'b0);
    read_expect(4'hc, 32'd0, 1'b1);

    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
